/* arp_rx_top.f */
+incdir+design
design/arp_rx_pkg.sv
design/eth_frame_if.sv
design/arp_frame_if.sv
design/eth_hdr_rx.sv
design/arp_eth_rx.sv
design/arp_match.sv
design/arp_rx_top.sv
tests/arp_rx_checker.sv
tests/arp_rx_tb.sv

/* design/arp_eth_rx.sv */
/*
 * ARP frame decoder
 * takes a decoded Ethernet header and its payload, splits the 28-byte
 * ARP body into fields and drains any padding up to tlast
 */
`include "arp_rx_defs.svh"

module arp_eth_rx
    import arp_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    eth_frame_if.snk s,
    arp_frame_if.src m,
    output logic     frame_error
);

    arp_state_t  state;
    logic [4:0]  ptr;
    logic        frame_valid;
    logic        hdr_take;
    logic        body_beat;
    logic        body_end;

    logic [47:0] src_mac;
    logic [15:0] eth_type;
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    logic [47:0] sha;
    logic [31:0] spa;
    logic [47:0] tha;
    logic [31:0] tpa;

    // no new header while the last decoded frame is still waiting
    assign s.hdr_ready = (state == ARP_IDLE) && !frame_valid;
    assign s.tready    = (state != ARP_IDLE);

    assign hdr_take  = s.hdr_valid && s.hdr_ready;
    assign body_beat = (state == ARP_READ_BODY) && s.tvalid;
    assign body_end  = (ptr == 5'(`ARP_BODY_LEN - 1));

    assign m.frame_valid = frame_valid;
    assign m.src_mac     = src_mac;
    assign m.eth_type    = eth_type;
    assign m.htype       = htype;
    assign m.ptype       = ptype;
    assign m.hlen        = hlen;
    assign m.plen        = plen;
    assign m.oper        = oper;
    assign m.sha         = sha;
    assign m.spa         = spa;
    assign m.tha         = tha;
    assign m.tpa         = tpa;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ARP_IDLE;
            ptr         <= '0;
            frame_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_error <= 1'b0;

            if (frame_valid && m.frame_ready) begin
                frame_valid <= 1'b0;
            end

            case (state)
                ARP_IDLE: begin
                    ptr <= '0;
                    if (hdr_take) begin
                        state <= ARP_READ_BODY;
                    end
                end
                ARP_READ_BODY: begin
                    if (s.tvalid) begin
                        ptr <= ptr + 5'd1;
                        if (body_end) begin
                            frame_valid <= 1'b1;
                            state       <= s.tlast ? ARP_IDLE : ARP_WAIT_LAST;
                        end else if (s.tlast) begin
                            // truncated body
                            frame_error <= 1'b1;
                            state       <= ARP_IDLE;
                        end
                    end
                end
                ARP_WAIT_LAST: begin
                    // discard padding
                    if (s.tvalid && s.tlast) begin
                        state <= ARP_IDLE;
                    end
                end
                default: begin
                    state <= ARP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_take) begin
            src_mac  <= s.src_mac;
            eth_type <= s.eth_type;
        end

        // fields are big endian on the wire
        if (body_beat) begin
            case (ptr)
                5'd0:  htype[15:8] <= s.tdata;
                5'd1:  htype[7:0]  <= s.tdata;
                5'd2:  ptype[15:8] <= s.tdata;
                5'd3:  ptype[7:0]  <= s.tdata;
                5'd4:  hlen        <= s.tdata;
                5'd5:  plen        <= s.tdata;
                5'd6:  oper[15:8]  <= s.tdata;
                5'd7:  oper[7:0]   <= s.tdata;
                5'd8:  sha[47:40]  <= s.tdata;
                5'd9:  sha[39:32]  <= s.tdata;
                5'd10: sha[31:24]  <= s.tdata;
                5'd11: sha[23:16]  <= s.tdata;
                5'd12: sha[15:8]   <= s.tdata;
                5'd13: sha[7:0]    <= s.tdata;
                5'd14: spa[31:24]  <= s.tdata;
                5'd15: spa[23:16]  <= s.tdata;
                5'd16: spa[15:8]   <= s.tdata;
                5'd17: spa[7:0]    <= s.tdata;
                5'd18: tha[47:40]  <= s.tdata;
                5'd19: tha[39:32]  <= s.tdata;
                5'd20: tha[31:24]  <= s.tdata;
                5'd21: tha[23:16]  <= s.tdata;
                5'd22: tha[15:8]   <= s.tdata;
                5'd23: tha[7:0]    <= s.tdata;
                5'd24: tpa[31:24]  <= s.tdata;
                5'd25: tpa[23:16]  <= s.tdata;
                5'd26: tpa[15:8]   <= s.tdata;
                5'd27: tpa[7:0]    <= s.tdata;
                default: ;
            endcase
        end
    end

endmodule

/* design/arp_frame_if.sv */
/*
 * ARP frame interface
 * one fully decoded ARP frame per frame_valid/frame_ready transfer
 */
interface arp_frame_if;

    logic        frame_valid;
    logic        frame_ready;
    logic [47:0] src_mac;
    logic [15:0] eth_type;
    logic [15:0] htype;
    logic [15:0] ptype;
    logic [7:0]  hlen;
    logic [7:0]  plen;
    logic [15:0] oper;
    logic [47:0] sha;
    logic [31:0] spa;
    logic [47:0] tha;
    logic [31:0] tpa;

    modport src (
        output frame_valid, src_mac, eth_type, htype, ptype, hlen, plen,
        output oper, sha, spa, tha, tpa,
        input  frame_ready
    );

    modport snk (
        input  frame_valid, src_mac, eth_type, htype, ptype, hlen, plen,
        input  oper, sha, spa, tha, tpa,
        output frame_ready
    );

endinterface

/* design/arp_match.sv */
/*
 * ARP frame filter
 * checks the fixed fields of a decoded frame, classifies the operation
 * and flags frames whose target IP is the local address
 */
`include "arp_rx_defs.svh"

module arp_match
    import arp_rx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    arp_frame_if.snk    s,
    input  logic [31:0] local_ip,
    output logic        arp_valid,
    input  logic        arp_ready,
    output arp_oper_t   oper,
    output logic [47:0] sender_mac,
    output logic [31:0] sender_ip,
    output logic [31:0] target_ip,
    output logic        for_us,
    output logic        drop
);

    logic      take;
    logic      fields_ok;
    arp_oper_t oper_dec;

    // accept when the output register is empty or being emptied
    assign s.frame_ready = !arp_valid || arp_ready;
    assign take          = s.frame_valid && s.frame_ready;

    assign fields_ok = (s.eth_type == `ARP_ETHERTYPE) &&
                       (s.htype == `ARP_HTYPE_ETH) &&
                       (s.ptype == `ARP_PTYPE_IPV4) &&
                       (s.hlen == `ARP_HLEN_ETH) &&
                       (s.plen == `ARP_PLEN_IPV4);

    always_comb begin
        case (s.oper)
            16'd1:   oper_dec = OPER_REQUEST;
            16'd2:   oper_dec = OPER_REPLY;
            default: oper_dec = OPER_OTHER;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            arp_valid <= 1'b0;
            drop      <= 1'b0;
        end else begin
            drop <= take && !fields_ok;
            if (take && fields_ok) begin
                arp_valid <= 1'b1;
            end else if (arp_ready) begin
                arp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && fields_ok) begin
            oper       <= oper_dec;
            sender_mac <= s.sha;
            sender_ip  <= s.spa;
            target_ip  <= s.tpa;
            for_us     <= (s.tpa == local_ip);
        end
    end

endmodule

/* design/arp_rx_defs.svh */
/*
 * ARP receive path constants
 * frame lengths and the fixed field values of an Ethernet/IPv4 ARP frame
 */
`ifndef ARP_RX_DEFS_SVH
`define ARP_RX_DEFS_SVH

// byte counts of the two frame sections
`define ARP_ETH_HDR_LEN 14
`define ARP_BODY_LEN 28

// ethertype that marks an ARP frame
`define ARP_ETHERTYPE 16'h0806

// fixed ARP body fields for Ethernet hardware and IPv4 protocol
`define ARP_HTYPE_ETH 16'd1
`define ARP_PTYPE_IPV4 16'h0800
`define ARP_HLEN_ETH 8'd6
`define ARP_PLEN_IPV4 8'd4

`endif

/* design/arp_rx_pkg.sv */
/*
 * ARP receive path types
 * FSM state encodings of the two parser stages and the decoded operation
 */
package arp_rx_pkg;

    // Ethernet header parser
    typedef enum logic [1:0] {
        HDR_IDLE    = 2'd0,
        HDR_READ    = 2'd1,
        HDR_PAYLOAD = 2'd2
    } hdr_state_t;

    // ARP body parser
    typedef enum logic [1:0] {
        ARP_IDLE      = 2'd0,
        ARP_READ_BODY = 2'd1,
        ARP_WAIT_LAST = 2'd2
    } arp_state_t;

    // request and reply keep their wire values
    typedef enum logic [1:0] {
        OPER_REQUEST = 2'd1,
        OPER_REPLY   = 2'd2,
        OPER_OTHER   = 2'd3
    } arp_oper_t;

endpackage

/* design/arp_rx_top.sv */
/*
 * ARP receive path
 * raw Ethernet bytes in, validated and classified ARP frames out
 */
module arp_rx_top (
    input  logic        clk,
    input  logic        rst,

    // raw frame input
    input  logic [7:0]  s_tdata,
    input  logic        s_tvalid,
    output logic        s_tready,
    input  logic        s_tlast,

    input  logic [31:0] local_ip,

    // decoded ARP output
    output logic        arp_valid,
    input  logic        arp_ready,
    output logic [1:0]  oper,
    output logic [47:0] sender_mac,
    output logic [31:0] sender_ip,
    output logic [31:0] target_ip,
    output logic        for_us,

    // one-cycle status pulses
    output logic        hdr_error,
    output logic        frame_error,
    output logic        drop
);

    eth_frame_if u_eth_if ();
    arp_frame_if u_arp_if ();

    eth_hdr_rx u_eth_hdr_rx (
        .clk       (clk),
        .rst       (rst),
        .s_tdata   (s_tdata),
        .s_tvalid  (s_tvalid),
        .s_tlast   (s_tlast),
        .s_tready  (s_tready),
        .hdr_error (hdr_error),
        .m         (u_eth_if.src)
    );

    arp_eth_rx u_arp_eth_rx (
        .clk         (clk),
        .rst         (rst),
        .s           (u_eth_if.snk),
        .m           (u_arp_if.src),
        .frame_error (frame_error)
    );

    arp_match u_arp_match (
        .clk        (clk),
        .rst        (rst),
        .s          (u_arp_if.snk),
        .local_ip   (local_ip),
        .arp_valid  (arp_valid),
        .arp_ready  (arp_ready),
        .oper       (oper),
        .sender_mac (sender_mac),
        .sender_ip  (sender_ip),
        .target_ip  (target_ip),
        .for_us     (for_us),
        .drop       (drop)
    );

endmodule

/* design/eth_frame_if.sv */
/*
 * Ethernet frame interface
 * decoded header with its own handshake, followed by the payload byte stream
 */
interface eth_frame_if;

    // header handshake
    logic        hdr_valid;
    logic        hdr_ready;
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic [15:0] eth_type;

    // payload stream
    logic [7:0]  tdata;
    logic        tvalid;
    logic        tready;
    logic        tlast;

    modport src (
        output hdr_valid,
        output dest_mac,
        output src_mac,
        output eth_type,
        output tdata,
        output tvalid,
        output tlast,
        input  hdr_ready,
        input  tready
    );

    modport snk (
        input  hdr_valid,
        input  dest_mac,
        input  src_mac,
        input  eth_type,
        input  tdata,
        input  tvalid,
        input  tlast,
        output hdr_ready,
        output tready
    );

endinterface

/* design/eth_hdr_rx.sv */
/*
 * Ethernet header receiver
 * collects the 14 header bytes of a raw frame, offers them as a decoded
 * header and then passes the payload bytes through until tlast
 */
`include "arp_rx_defs.svh"

module eth_hdr_rx
    import arp_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] s_tdata,
    input  logic       s_tvalid,
    input  logic       s_tlast,
    output logic       s_tready,
    output logic       hdr_error,
    eth_frame_if.src   m
);

    hdr_state_t   state;
    logic [3:0]   byte_cnt;
    logic [111:0] hdr_sr;
    logic         hdr_valid;
    logic         hdr_beat;
    logic         pay_last;

    // header bytes are taken only while collecting, payload follows the sink
    assign s_tready = (state == HDR_READ) || ((state == HDR_PAYLOAD) && m.tready);

    assign hdr_beat = (state == HDR_READ) && s_tvalid;
    assign pay_last = (state == HDR_PAYLOAD) && s_tvalid && m.tready && s_tlast;

    // dest mac arrives first and ends up in the top bits
    assign m.dest_mac  = hdr_sr[111:64];
    assign m.src_mac   = hdr_sr[63:16];
    assign m.eth_type  = hdr_sr[15:0];
    assign m.hdr_valid = hdr_valid;

    // payload is passed through without a register
    assign m.tdata  = s_tdata;
    assign m.tvalid = (state == HDR_PAYLOAD) && s_tvalid;
    assign m.tlast  = s_tlast;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= HDR_IDLE;
            byte_cnt  <= '0;
            hdr_valid <= 1'b0;
            hdr_error <= 1'b0;
        end else begin
            hdr_error <= 1'b0;

            if (hdr_valid && m.hdr_ready) begin
                hdr_valid <= 1'b0;
            end

            case (state)
                HDR_IDLE: begin
                    // one idle cycle between frames
                    byte_cnt <= '0;
                    state    <= HDR_READ;
                end
                HDR_READ: begin
                    if (s_tvalid) begin
                        byte_cnt <= byte_cnt + 4'd1;
                        if (s_tlast) begin
                            // frame ended inside the header, throw it away
                            hdr_error <= 1'b1;
                            state     <= HDR_IDLE;
                        end else if (byte_cnt == 4'(`ARP_ETH_HDR_LEN - 1)) begin
                            hdr_valid <= 1'b1;
                            state     <= HDR_PAYLOAD;
                        end
                    end
                end
                HDR_PAYLOAD: begin
                    if (pay_last) begin
                        state <= HDR_IDLE;
                    end
                end
                default: begin
                    state <= HDR_IDLE;
                end
            endcase
        end
    end

    // header shift register, frozen once all 14 bytes are in
    always_ff @(posedge clk) begin
        if (hdr_beat) begin
            hdr_sr <= {hdr_sr[103:0], s_tdata};
        end
    end

endmodule

/* tests/arp_rx_checker.sv */
/*
 * ARP receive path checker
 * output handshake and status pulse assertions, bound into the top level
 */
module arp_rx_checker (
    input logic        clk,
    input logic        rst,
    input logic        s_tready,
    input logic        arp_valid,
    input logic        arp_ready,
    input logic [1:0]  oper,
    input logic [47:0] sender_mac,
    input logic [31:0] sender_ip,
    input logic [31:0] target_ip,
    input logic        for_us,
    input logic        hdr_error,
    input logic        frame_error,
    input logic        drop
);

    int assert_failures = 0;

    // a stalled output keeps its valid and its data
    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        arp_valid && !arp_ready |=> arp_valid &&
        $stable({oper, sender_mac, sender_ip, target_ip, for_us}))
    else begin
        assert_failures++;
        $error("arp_valid or its data changed while arp_ready was low");
    end

    // input and output handshakes stay idle while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !s_tready && !arp_valid)
    else begin
        assert_failures++;
        $error("s_tready or arp_valid high during reset");
    end

    // a drop may meet a header error of a later frame, these pairs may not
    a_parse_errors: assert property (@(posedge clk) disable iff (rst)
        !(hdr_error && frame_error) && !(frame_error && drop))
    else begin
        assert_failures++;
        $error("two status pulses in the same cycle");
    end

endmodule

/* tests/arp_rx_tb.sv */
/*
 * ARP receive path testbench
 * random Ethernet frames from an LCG, random padding, gaps and output
 * back-pressure, with results compared against a reference queue
 */
`include "arp_rx_defs.svh"

module arp_rx_tb
    import arp_rx_pkg::*;
;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_FRAMES      = 80;
    localparam int MAX_FRAME_LEN   = `ARP_ETH_HDR_LEN + `ARP_BODY_LEN + 18;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_FRAME_LEN * 4 + 16 + 500;
    localparam int ERR_HDR         = 1;
    localparam int ERR_FRAME       = 2;

    // one entry per frame that reaches the filter stage
    typedef struct packed {
        logic        is_drop;
        logic [1:0]  oper;
        logic [47:0] sender_mac;
        logic [31:0] sender_ip;
        logic [31:0] target_ip;
        logic        for_us;
    } path_result_t;

    logic        clk;
    logic        rst;
    logic [7:0]  s_tdata;
    logic        s_tvalid;
    logic        s_tready;
    logic        s_tlast;
    logic [31:0] local_ip;
    logic        arp_valid;
    logic        arp_ready;
    logic [1:0]  oper;
    logic [47:0] sender_mac;
    logic [31:0] sender_ip;
    logic [31:0] target_ip;
    logic        for_us;
    logic        hdr_error;
    logic        frame_error;
    logic        drop;

    logic [31:0]  stim_state;
    logic [31:0]  bp_state;
    path_result_t path_q[$];
    int           err_q[$];

    arp_rx_top u_dut (.*);

    bind arp_rx_top arp_rx_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .s_tready    (s_tready),
        .arp_valid   (arp_valid),
        .arp_ready   (arp_ready),
        .oper        (oper),
        .sender_mac  (sender_mac),
        .sender_ip   (sender_ip),
        .target_ip   (target_ip),
        .for_us      (for_us),
        .hdr_error   (hdr_error),
        .frame_error (frame_error),
        .drop        (drop)
    );

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    task automatic halt_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            halt_with_failure();
        end
    endtask

    task automatic match_error(input int kind, input string name);
        if (err_q.size() == 0) begin
            $display("%s pulsed at time %0t with no malformed frame outstanding", name, $time);
            halt_with_failure();
        end else begin
            check_value("error_kind", kind, err_q.pop_front());
        end
    endtask

    // drives one byte on the input stream between two falling edges
    task automatic send_byte(input logic [7:0] data, input logic last);
        logic [31:0] r;
        r = lcg_next(stim_state);
        if (r[2:0] == 3'd0) begin
            repeat (1 + r[4:3]) @(negedge clk);
        end
        s_tdata  = data;
        s_tvalid = 1'b1;
        s_tlast  = last;
        @(posedge clk);
        while (!s_tready) @(posedge clk);
        @(negedge clk);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // frame kinds are 0 request, 1 reply, 2 other oper, 3 bad field,
    // 4 short header and 5 short body
    task automatic send_frame(input int idx);
        logic [31:0]  r;
        logic [31:0]  v;
        int           kind;
        int           len;
        int           k;
        logic         hit;
        logic [47:0]  dest_mac;
        logic [47:0]  src_mac;
        logic [15:0]  eth_type;
        logic [15:0]  htype;
        logic [15:0]  ptype;
        logic [7:0]   hlen;
        logic [7:0]   plen;
        logic [15:0]  oper16;
        logic [47:0]  sha;
        logic [47:0]  tha;
        logic [31:0]  spa;
        logic [31:0]  tpa;
        logic [111:0] hdr;
        logic [223:0] body;
        logic [7:0]   bytes [0:MAX_FRAME_LEN-1];
        path_result_t exp;
        r = lcg_next(stim_state);
        if (idx < 6) begin
            kind = idx;
            hit  = (idx == 0);
        end else begin
            case (r[2:0])
                3'd0, 3'd1: kind = 0;
                3'd2, 3'd3: kind = 1;
                3'd4:       kind = 2;
                3'd5:       kind = 3;
                3'd6:       kind = 4;
                default:    kind = 5;
            endcase
            hit = r[4];
        end

        eth_type = `ARP_ETHERTYPE;
        htype    = `ARP_HTYPE_ETH;
        ptype    = `ARP_PTYPE_IPV4;
        hlen     = `ARP_HLEN_ETH;
        plen     = `ARP_PLEN_IPV4;
        case (kind)
            0:       oper16 = 16'd1;
            1:       oper16 = 16'd2;
            // zero or a value with a nonzero high byte
            2:       oper16 = r[3] ? 16'd0 : {r[23:16] | 8'h01, r[15:8]};
            default: oper16 = 16'd1 + r[3];
        endcase

        v = lcg_next(stim_state);
        dest_mac = {v[15:0], lcg_next(stim_state)};
        v = lcg_next(stim_state);
        src_mac = {v[15:0], lcg_next(stim_state)};
        v = lcg_next(stim_state);
        sha = {v[15:0], lcg_next(stim_state)};
        v = lcg_next(stim_state);
        tha = {v[15:0], lcg_next(stim_state)};
        spa = lcg_next(stim_state);
        // a miss differs from the local address in at least bit 0
        v   = lcg_next(stim_state);
        tpa = hit ? local_ip : (local_ip ^ (v | 32'h1));

        if (kind == 3) begin
            case ((r >> 5) % 5)
                0:       eth_type = eth_type ^ (16'h1 << r[11:8]);
                1:       htype    = htype ^ (16'h1 << r[11:8]);
                2:       ptype    = ptype ^ (16'h1 << r[11:8]);
                3:       hlen     = hlen ^ (8'h1 << r[10:8]);
                default: plen     = plen ^ (8'h1 << r[10:8]);
            endcase
        end

        hdr  = {dest_mac, src_mac, eth_type};
        body = {htype, ptype, hlen, plen, oper16, sha, spa, tha, tpa};
        for (k = 0; k < `ARP_ETH_HDR_LEN; k++) begin
            bytes[k] = hdr[111 - 8*k -: 8];
        end
        for (k = 0; k < `ARP_BODY_LEN; k++) begin
            bytes[`ARP_ETH_HDR_LEN + k] = body[223 - 8*k -: 8];
        end
        for (k = `ARP_ETH_HDR_LEN + `ARP_BODY_LEN; k < MAX_FRAME_LEN; k++) begin
            v = lcg_next(stim_state);
            bytes[k] = v[7:0];
        end

        // reference result is queued before the first byte goes out
        exp.is_drop    = (kind == 3);
        exp.sender_mac = sha;
        exp.sender_ip  = spa;
        exp.target_ip  = tpa;
        exp.for_us     = hit;
        case (kind)
            0:       exp.oper = OPER_REQUEST;
            1:       exp.oper = OPER_REPLY;
            default: exp.oper = OPER_OTHER;
        endcase
        if (kind == 4) begin
            len = 1 + (r >> 12) % `ARP_ETH_HDR_LEN;
            err_q.push_back(ERR_HDR);
        end else if (kind == 5) begin
            len = `ARP_ETH_HDR_LEN + 1 + (r >> 12) % (`ARP_BODY_LEN - 1);
            err_q.push_back(ERR_FRAME);
        end else begin
            len = `ARP_ETH_HDR_LEN + `ARP_BODY_LEN + (r >> 12) % 19;
            path_q.push_back(exp);
        end

        for (k = 0; k < len; k++) begin
            send_byte(bytes[k], k == len - 1);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // output back-pressure in random stretches with arp_ready mostly high
    initial begin
        logic [31:0] r;
        bp_state = 32'h175e8b7e ^ 32'h5a5a5a5a;
        @(negedge rst);
        forever begin
            r = lcg_next(bp_state);
            arp_ready = (r[11:10] != 2'd0);
            repeat (1 + r[7:0] % 12) @(negedge clk);
        end
    end

    // result monitor
    initial begin
        path_result_t exp;
        forever begin
            @(posedge clk);
            if (!rst) begin
                if (u_dut.u_checker.assert_failures != 0) begin
                    $display("a handshake assertion failed by time %0t", $time);
                    halt_with_failure();
                end
                if (hdr_error) begin
                    match_error(ERR_HDR, "hdr_error");
                end
                if (frame_error) begin
                    match_error(ERR_FRAME, "frame_error");
                end
                if (drop || (arp_valid && arp_ready)) begin
                    if (path_q.size() == 0) begin
                        $display("unexpected %s at time %0t with no frame outstanding",
                                 drop ? "drop" : "output", $time);
                        halt_with_failure();
                    end else begin
                        exp = path_q.pop_front();
                        check_value("drop", drop, exp.is_drop);
                        if (!drop) begin
                            check_value("oper", oper, exp.oper);
                            check_value("sender_mac", sender_mac, exp.sender_mac);
                            check_value("sender_ip", sender_ip, exp.sender_ip);
                            check_value("target_ip", target_ip, exp.target_ip);
                            check_value("for_us", for_us, exp.for_us);
                        end
                    end
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles, %0d outputs and %0d errors still outstanding",
                 WATCHDOG_CYCLES, path_q.size(), err_q.size());
        halt_with_failure();
    end

    initial begin
        int i;
        rst        = 1'b1;
        s_tdata    = 8'h00;
        s_tvalid   = 1'b0;
        s_tlast    = 1'b0;
        arp_ready  = 1'b0;
        stim_state = 32'h175e8b7e;
        local_ip   = lcg_next(stim_state);
        repeat (16) @(negedge clk);
        rst = 1'b0;

        for (i = 0; i < NUM_FRAMES; i++) begin
            send_frame(i);
        end
        while (path_q.size() != 0 || err_q.size() != 0) @(posedge clk);

        // catch late or repeated results
        repeat (50) @(posedge clk);
        if (u_dut.u_checker.assert_failures != 0) begin
            $display("a handshake assertion failed near the end of the run");
            halt_with_failure();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
